/* rtl/icache_pkg.sv */
package icache_pkg;

    // cache shape
    localparam int WAYS            = 4;
    localparam int SETS            = 16;
    localparam int DWORDS_PER_LINE = 4;
    localparam int WORDS_PER_LINE  = 8;
    localparam int DATA_WIDTH      = 64;
    localparam int WORD_WIDTH      = 32;

    localparam int WAY_BITS       = $clog2(WAYS);
    localparam int INDEX_BITS     = $clog2(SETS);
    localparam int OFFSET_BITS    = $clog2(DWORDS_PER_LINE);
    localparam int ALIGN_BITS     = $clog2(DATA_WIDTH / 8);
    localparam int TAG_BITS       = 32 - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;
    localparam int DATA_ADDR_BITS = WAY_BITS + INDEX_BITS + OFFSET_BITS;
    localparam int WORD_SEL_BITS  = $clog2(WORDS_PER_LINE);

    typedef logic [TAG_BITS-1:0]       tag_t;
    typedef logic [INDEX_BITS-1:0]     index_t;
    typedef logic [OFFSET_BITS-1:0]    offset_t;
    typedef logic [WAY_BITS-1:0]       way_t;
    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [WAYS-2:0]           plru_t;
    typedef logic [WORD_SEL_BITS-1:0]  word_sel_t;
    // {way, index, offset}
    typedef logic [DATA_ADDR_BITS-1:0] data_addr_t;

    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [ALIGN_BITS-1:0] align;
    } lookup_view_t;

    // line address, word in line, byte in word
    typedef struct packed {
        logic [TAG_BITS+INDEX_BITS-1:0] line;
        word_sel_t                      word;
        logic [1:0]                     byte_sel;
    } refill_view_t;

    typedef union packed {
        lookup_view_t lookup;
        refill_view_t refill;
    } cache_addr_u;

    typedef enum logic {
        IDLE,
        FETCH
    } fsm_state_t;

endpackage

/* rtl/icache_plru.sv */
module icache_plru
    import icache_pkg::*;
(
    input  plru_t plru_old,
    input  way_t  touch_way,
    output plru_t plru_new,
    output way_t  victim_way
);

    // bit 0 picks the half, bit 1 ways 0/1, bit 2 ways 2/3
    // a zero bit points at the lower side as least recently used

    always_comb begin
        if (plru_old[0] == 1'b0) begin
            victim_way = {1'b0, plru_old[1]};
        end else begin
            victim_way = {1'b1, plru_old[2]};
        end
    end

    // point every bit on the path away from the touched way
    always_comb begin
        plru_new    = plru_old;
        plru_new[0] = ~touch_way[1];
        if (touch_way[1] == 1'b0) begin
            plru_new[1] = ~touch_way[0];
        end else begin
            plru_new[2] = ~touch_way[0];
        end
    end

endmodule

/* rtl/ram_single_port.sv */
module ram_single_port
    import icache_pkg::*;
(
    input  logic            clk,
    input  logic            we,
    input  index_t          addr,
    input  tag_t [WAYS-1:0] wdata,
    output tag_t [WAYS-1:0] rdata
);

    // one entry per set, all ways side by side
    tag_t [WAYS-1:0] mem [SETS];

    assign rdata = mem[addr];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

endmodule

/* rtl/bram_dual_port.sv */
module bram_dual_port
    import icache_pkg::*;
(
    input  logic                    clk,

    // port 1, fetch read
    input  logic                    en_1,
    input  data_addr_t              addr_1,
    output data_t                   data_out_1,

    // port 2, refill write
    input  logic [DATA_WIDTH/8-1:0] strobe_2,
    input  data_addr_t              addr_2,
    input  data_t                   data_in_2
);

    localparam int DEPTH = 2 ** DATA_ADDR_BITS;

    data_t mem [DEPTH];

    // read first, a write in the same cycle shows up one read later
    always_ff @(posedge clk) begin
        if (en_1) begin
            data_out_1 <= mem[addr_1];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DATA_WIDTH / 8; i++) begin
            if (strobe_2[i]) begin
                mem[addr_2][i*8 +: 8] <= data_in_2[i*8 +: 8];
            end
        end
    end

endmodule

/* rtl/icache.sv */
module icache
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,

    input  logic        ireq_valid,
    input  cache_addr_u ireq_addr,
    output logic        iresp_addr_ok,
    output logic        iresp_data_ok,
    output data_t       iresp_data,

    output logic        creq_valid,
    output cache_addr_u creq_addr,
    input  logic        cresp_ready,
    input  logic        cresp_last,
    input  word_t       cresp_data
);

    fsm_state_t                state_q;
    cache_addr_u               fill_addr_q;
    way_t                      fill_way_q;
    word_sel_t                 fill_word_q;
    logic [WORDS_PER_LINE-1:0] done_q;
    logic [SETS-1:0][WAYS-1:0] valid_q;
    plru_t [SETS-1:0]          plru_q;
    logic                      data_ok_q;

    index_t          req_index;
    tag_t [WAYS-1:0] tag_r;
    tag_t [WAYS-1:0] tag_w;
    logic            hit;
    way_t            hit_way;
    logic            same_line;
    logic            dword_done;
    logic            hit_avail;
    logic            req_hit;
    logic            req_miss;

    plru_t plru_new;
    way_t  victim_way;
    way_t  touch_way;

    data_addr_t              rd_addr;
    data_addr_t              fill_data_addr;
    logic [DATA_WIDTH/8-1:0] fill_strobe;

    assign req_index = ireq_addr.lookup.index;

    ram_single_port i_tag_ram (
        .clk   (clk),
        .we    (req_miss),
        .addr  (req_index),
        .wdata (tag_w),
        .rdata (tag_r)
    );

    // at most one way can match
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (valid_q[req_index][i] && tag_r[i] == ireq_addr.lookup.tag) begin
                hit     = 1'b1;
                hit_way = way_t'(i);
            end
        end
    end

    // hits on the refilling line wait for both halves of the data word
    assign same_line  = ireq_addr.refill.line == fill_addr_q.refill.line;
    assign dword_done = done_q[{ireq_addr.lookup.offset, 1'b0}]
                        && done_q[{ireq_addr.lookup.offset, 1'b1}];
    assign hit_avail  = state_q == IDLE || !same_line || dword_done;

    assign req_hit  = ireq_valid && hit && hit_avail;
    // one miss at a time
    assign req_miss = ireq_valid && !hit && state_q == IDLE;

    always_comb begin
        tag_w             = tag_r;
        tag_w[victim_way] = ireq_addr.lookup.tag;
    end

    assign touch_way = req_miss ? victim_way : hit_way;

    icache_plru i_plru (
        .plru_old   (plru_q[req_index]),
        .touch_way  (touch_way),
        .plru_new   (plru_new),
        .victim_way (victim_way)
    );

    assign rd_addr        = {hit_way, req_index, ireq_addr.lookup.offset};
    assign fill_data_addr = {fill_way_q, fill_addr_q.lookup.index,
                             fill_word_q[WORD_SEL_BITS-1:1]};

    // odd word goes to the upper half
    always_comb begin
        fill_strobe = '0;
        if (state_q == FETCH && cresp_ready) begin
            fill_strobe = fill_word_q[0] ? 8'hf0 : 8'h0f;
        end
    end

    bram_dual_port i_data_ram (
        .clk        (clk),
        .en_1       (req_hit),
        .addr_1     (rd_addr),
        .data_out_1 (iresp_data),
        .strobe_2   (fill_strobe),
        .addr_2     (fill_data_addr),
        .data_in_2  ({cresp_data, cresp_data})
    );

    always_ff @(posedge clk) begin
        if (resetn) begin
            state_q     <= IDLE;
            fill_word_q <= '0;
            done_q      <= '0;
            valid_q     <= '0;
            plru_q      <= '0;
            data_ok_q   <= 1'b0;
        end else begin
            data_ok_q <= req_hit;
            if (req_hit || req_miss) begin
                plru_q[req_index] <= plru_new;
            end
            if (req_miss) begin
                valid_q[req_index][victim_way] <= 1'b1;
                state_q     <= FETCH;
                fill_word_q <= ireq_addr.refill.word;
                done_q      <= '0;
            end else if (state_q == FETCH && cresp_ready) begin
                // burst wraps within the line
                done_q[fill_word_q] <= 1'b1;
                fill_word_q         <= fill_word_q + word_sel_t'(1);
                if (cresp_last) begin
                    state_q <= IDLE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_miss) begin
            fill_addr_q <= ireq_addr;
            fill_way_q  <= victim_way;
        end
    end

    assign iresp_addr_ok = req_hit;
    assign iresp_data_ok = data_ok_q;

    assign creq_valid = state_q == FETCH;
    assign creq_addr  = fill_addr_q;

endmodule

/* rtl/icache_top.sv */
module icache_top
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,

    // fetch side
    input  logic        ireq_valid,
    input  cache_addr_u ireq_addr,
    output logic        iresp_addr_ok,
    output logic        iresp_data_ok,
    output data_t       iresp_data,

    // memory side, fixed 8 word burst
    output logic        creq_valid,
    output cache_addr_u creq_addr,
    input  logic        cresp_ready,
    input  logic        cresp_last,
    input  word_t       cresp_data
);

    icache i_icache (
        .clk           (clk),
        .resetn        (resetn),
        .ireq_valid    (ireq_valid),
        .ireq_addr     (ireq_addr),
        .iresp_addr_ok (iresp_addr_ok),
        .iresp_data_ok (iresp_data_ok),
        .iresp_data    (iresp_data),
        .creq_valid    (creq_valid),
        .creq_addr     (creq_addr),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data)
    );

endmodule

/* testbench/icache_assertions.sv */
module icache_assertions
    import icache_pkg::*;
(
    input logic        clk,
    input logic        resetn,
    input logic        ireq_valid,
    input logic        iresp_addr_ok,
    input logic        iresp_data_ok,
    input logic        creq_valid,
    input cache_addr_u creq_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    // response exactly one cycle after acceptance, never otherwise
    data_ok_follows: assert property (@(posedge clk) disable iff (resetn)
        iresp_addr_ok |=> iresp_data_ok)
        else $error("iresp_data_ok missing one cycle after iresp_addr_ok");
    no_stray_data_ok: assert property (@(posedge clk) disable iff (resetn)
        !iresp_addr_ok |=> !iresp_data_ok)
        else $error("iresp_data_ok without an accepted request");

    addr_ok_needs_valid: assert property (@(posedge clk) disable iff (resetn)
        iresp_addr_ok |-> ireq_valid)
        else $error("iresp_addr_ok high while ireq_valid is low");

    creq_addr_stable: assert property (@(posedge clk) disable iff (resetn)
        creq_valid && $past(creq_valid) |-> $stable(creq_addr))
        else $error("creq_addr changed during a burst request");

    creq_idle_after_reset: assert property (@(posedge clk) resetn |=> !creq_valid)
        else $error("creq_valid high in the cycle after reset");

endmodule

bind icache_top icache_assertions i_icache_assertions (
    .clk           (clk),
    .resetn        (resetn),
    .ireq_valid    (ireq_valid),
    .iresp_addr_ok (iresp_addr_ok),
    .iresp_data_ok (iresp_data_ok),
    .creq_valid    (creq_valid),
    .creq_addr     (creq_addr)
);

/* testbench/tb_icache.sv */
module tb_icache
    import icache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD     = 10;
    localparam int NUM_REQUESTS   = 220;
    localparam int TIMEOUT_CYCLES = 40;

    logic        clk;
    logic        resetn;
    logic        ireq_valid;
    cache_addr_u ireq_addr;
    logic        iresp_addr_ok;
    logic        iresp_data_ok;
    data_t       iresp_data;
    logic        creq_valid;
    cache_addr_u creq_addr;
    logic        cresp_ready;
    logic        cresp_last;
    word_t       cresp_data;

    integer      seed = 32'h9c17cc49;
    int          cycle;
    int          burst_count;
    int          model_misses;
    cache_addr_u miss_addr;
    tag_t        model_tag   [SETS][WAYS];
    logic        model_valid [SETS][WAYS];
    plru_t       model_plru  [SETS];

    // accepted requests, in order
    data_t exp_data  [256];
    int    exp_cycle [256];
    int    wr_ptr;
    int    rd_ptr;

    icache_top i_icache_top (
        .clk           (clk),
        .resetn        (resetn),
        .ireq_valid    (ireq_valid),
        .ireq_addr     (ireq_addr),
        .iresp_addr_ok (iresp_addr_ok),
        .iresp_data_ok (iresp_data_ok),
        .iresp_data    (iresp_data),
        .creq_valid    (creq_valid),
        .creq_addr     (creq_addr),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data)
    );

    initial begin
        clk   = 1'b0;
        cycle = 0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
            if (clk) begin
                cycle++;
            end
        end
    end

    // memory contents, a scramble of the word address
    function automatic word_t mem_word(logic [31:0] a);
        logic [31:0] w;
        w = {2'b00, a[31:2]};
        return (w * 32'h9e3779b1) ^ 32'h5ac30f96;
    endfunction

    function automatic data_t expected_data(cache_addr_u addr);
        logic [31:0] base;
        base      = addr;
        base[2:0] = 3'b000;
        return {mem_word(base + 32'd4), mem_word(base)};
    endfunction

    function automatic way_t plru_victim(plru_t p);
        if (p[0] == 1'b0) begin
            return p[1] ? 2'd1 : 2'd0;
        end else begin
            return p[2] ? 2'd3 : 2'd2;
        end
    endfunction

    // path bits point away from the used way
    function automatic plru_t plru_touch(plru_t p, way_t w);
        plru_t n;
        n = p;
        if (w[1] == 1'b0) begin
            n[0] = 1'b1;
            n[1] = (w == 2'd0);
        end else begin
            n[0] = 1'b0;
            n[2] = (w == 2'd2);
        end
        return n;
    endfunction

    // reference cache, returns 1 for a predicted miss
    function automatic logic model_access(cache_addr_u a);
        index_t s;
        way_t   w;
        logic   hit;
        s   = a.lookup.index;
        hit = 1'b0;
        w   = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (model_valid[s][i] && model_tag[s][i] == a.lookup.tag) begin
                hit = 1'b1;
                w   = way_t'(i);
            end
        end
        if (!hit) begin
            w                 = plru_victim(model_plru[s]);
            model_valid[s][w] = 1'b1;
            model_tag[s][w]   = a.lookup.tag;
        end
        model_plru[s] = plru_touch(model_plru[s], w);
        return !hit;
    endfunction

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_addr(string name, cache_addr_u got, cache_addr_u exp);
        if (got !== exp) begin
            fail_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            fail_run($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // one request, held until accepted; called just after a falling edge
    task automatic fetch(logic [31:0] addr);
        cache_addr_u a;
        logic        miss;
        int          bursts_before;
        a    = addr;
        miss = model_access(a);
        if (miss) begin
            model_misses++;
            miss_addr = a;
        end
        bursts_before = burst_count;
        ireq_valid    = 1'b1;
        ireq_addr     = a;
        #1;
        while (!iresp_addr_ok) begin
            @(negedge clk);
            #1;
        end
        exp_data[wr_ptr % 256]  = expected_data(a);
        exp_cycle[wr_ptr % 256] = cycle;
        wr_ptr++;
        @(negedge clk);
        ireq_valid = 1'b0;
        check_count("burst_count delta", burst_count - bursts_before, miss ? 1 : 0);
    endtask

    // 8 beats from the requested word, wrapping inside the line
    task automatic serve_burst(cache_addr_u a);
        cache_addr_u beat;
        int          stall;
        beat                 = a;
        beat.refill.byte_sel = 2'b00;
        for (int b = 0; b < WORDS_PER_LINE; b++) begin
            stall = $unsigned($random(seed)) % 4;
            repeat (stall) @(negedge clk);
            cresp_ready = 1'b1;
            cresp_last  = (b == WORDS_PER_LINE - 1);
            cresp_data  = mem_word(beat);
            @(negedge clk);
            cresp_ready      = 1'b0;
            cresp_last       = 1'b0;
            beat.refill.word = beat.refill.word + word_sel_t'(1);
        end
    endtask

    initial begin
        cresp_ready = 1'b0;
        cresp_last  = 1'b0;
        cresp_data  = '0;
        burst_count = 0;
        forever begin
            @(negedge clk);
            if (!resetn && creq_valid) begin
                burst_count++;
                check_addr("creq_addr", creq_addr, miss_addr);
                serve_burst(creq_addr);
            end
        end
    end

    initial begin
        rd_ptr = 0;
        forever begin
            @(negedge clk);
            if (!resetn && iresp_data_ok) begin
                if (rd_ptr == wr_ptr) begin
                    fail_run("iresp_data_ok arrived with no request outstanding");
                end else begin
                    check_data("iresp_data", iresp_data, exp_data[rd_ptr % 256]);
                    check_count("data_ok latency", cycle - exp_cycle[rd_ptr % 256], 1);
                    rd_ptr++;
                end
            end
        end
    end

    initial begin
        #(NUM_REQUESTS * TIMEOUT_CYCLES * CLK_PERIOD);
        fail_run("timeout: the tests did not finish in time");
    end

    initial begin
        logic [31:0] addr;
        resetn       = 1'b1;
        ireq_valid   = 1'b0;
        ireq_addr    = '0;
        wr_ptr       = 0;
        model_misses = 0;
        miss_addr    = '0;
        for (int s = 0; s < SETS; s++) begin
            model_plru[s] = '0;
            for (int w = 0; w < WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        repeat (3) @(negedge clk);
        resetn = 1'b0;
        @(negedge clk);

        // cold miss, then every data word of the same line
        fetch(32'h0000_1004);
        check_count("burst_count", burst_count, 1);
        fetch(32'h0000_1000);
        fetch(32'h0000_1008);
        fetch(32'h0000_1010);
        fetch(32'h0000_1018);
        fetch(32'h0000_1004);
        check_count("burst_count", burst_count, 1);

        // hits while the line of set 0 refills
        fetch(32'h0000_2010);
        fetch(32'h0000_1008);
        if (!creq_valid) begin
            fail_run("hit on a resident line waited for the refill to end");
        end
        fetch(32'h0000_2018);
        fetch(32'h0000_2000);

        // five lines in set 3, then revisit
        for (int k = 0; k < 5; k++) begin
            fetch(32'h0000_4060 + k * 32'h200);
        end
        fetch(32'h0000_4060);
        fetch(32'h0000_4460);
        fetch(32'h0000_4260);
        fetch(32'h0000_4860);
        fetch(32'h0000_4660);
        check_count("burst_count", burst_count, model_misses);

        repeat (200) begin
            addr = $random(seed);
            fetch(32'h0000_8000 | (addr & 32'h0000_07fc));
        end

        repeat (2) @(negedge clk);
        check_count("outstanding requests", wr_ptr - rd_ptr, 0);
        check_count("burst_count", burst_count, model_misses);
        $display("Everything OK");
        $finish;
    end

endmodule

/* icache.f */
rtl/icache_pkg.sv
rtl/icache_plru.sv
rtl/ram_single_port.sv
rtl/bram_dual_port.sv
rtl/icache.sv
rtl/icache_top.sv
testbench/icache_assertions.sv
testbench/tb_icache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the icache testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_icache -f icache.f \
    -o tb_icache > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_icache > sim.log 2>&1 || echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && { echo "simulation FAILED"; exit 1; } || echo "simulation passed"
